// ==== sources.f ====
logic/soc_bus_pkg.sv
logic/bus_decoder.sv
logic/bram_wb8.sv
logic/prng_wb8.sv
logic/timer_wb8.sv
logic/periph_bus_top.sv
bench/periph_bus_checker.sv
bench/periph_bus_tb.sv

// ==== Makefile ====
TOP := periph_bus_tb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module periph_bus_top -f sources.f
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

$(OBJ)/$(TOP): sources.f logic/*.sv bench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f \
		--Mdir $(OBJ) -o $(TOP)

sim: $(OBJ)/$(TOP)
	./$(OBJ)/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== bench/periph_bus_tb.sv ====
`timescale 1ns/1ps

module periph_bus_tb import soc_bus_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int ACK_LIMIT    = 8;
    localparam int NUM_TESTS    = 5;
    localparam int RELOAD_LONG  = 261;
    localparam int RELOAD_SHORT = 3;

    typedef enum logic [1:0] {
        op_wr,
        op_rd,
        op_wait,
        op_irq
    } op_e;

    // adr holds the cycle count for op_wait
    typedef struct packed {
        op_e        op;
        bus_adr_t   adr;
        bus_dat_t   wdat;
        bus_dat_t   exp;
        logic [3:0] test;
    } step_t;

    logic     clk;
    logic     arst_n_i;
    logic     stb_i;
    bus_req_t req_i;
    bus_rsp_t rsp_o;
    logic     irq_o;

    step_t       steps [$];
    int          errs [1:NUM_TESTS];
    logic [31:0] lcg_state = 32'h4f64;
    int          max_wait;
    int          limit_cycles;
    bit          table_built;

    periph_bus_top uut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (stb_i),
        .req_i    (req_i),
        .rsp_o    (rsp_o),
        .irq_o    (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        lcg_state = lcg_next(lcg_state);
        r = lcg_state;
    endtask

    // reference Galois LFSR
    function automatic logic [31:0] prng_model(input logic [31:0] s);
        logic [31:0] fb;
        fb = s[0] ? PRNG_TAPS : 32'h0;
        return {1'b0, s[31:1]} ^ fb;
    endfunction

    function automatic bus_adr_t timer_adr(input logic [1:0] ofs);
        return {TIMER_BASE, 6'b000000, ofs};
    endfunction

    function automatic bus_adr_t prng_adr(input int ofs);
        return {PRNG_BASE, 6'b000000, 2'(ofs)};
    endfunction

    task automatic add_step(input op_e op, input bus_adr_t adr, input bus_dat_t wdat,
                            input bus_dat_t exp, input int t);
        step_t s;
        s.op   = op;
        s.adr  = adr;
        s.wdat = wdat;
        s.exp  = exp;
        s.test = t[3:0];
        steps.push_back(s);
    endtask

    task automatic build_table();
        bus_adr_t    ram_adrs [6];
        bus_dat_t    ram_dats [6];
        logic [31:0] r;
        logic [31:0] s;
        bus_adr_t    long_wait;
        bus_adr_t    short_wait;
        ram_adrs   = '{32'h0000_0000, 32'h0000_0001, 32'h0000_0155,
                       32'h0000_02AA, 32'h0000_03FF, 32'h1234_5100};
        long_wait  = bus_adr_t'((RELOAD_LONG + 2) * TIMER_PRESCALE);
        short_wait = bus_adr_t'((RELOAD_SHORT + 2) * TIMER_PRESCALE);
        for (int k = 0; k < 6; k++) begin
            next_rand(r);
            ram_dats[k] = r[23:16];
            add_step(op_wr, ram_adrs[k], ram_dats[k], 8'h00, 1);
        end
        for (int k = 0; k < 6; k++) begin
            add_step(op_rd, ram_adrs[k], 8'h00, ram_dats[k], 1);
        end
        // 12345100 and 00000100 share the low ten bits
        add_step(op_rd, 32'h0000_0100, 8'h00, ram_dats[5], 1);
        next_rand(r);
        // low ten bits of FFFFFA37 are 237
        add_step(op_wr, 32'hFFFF_FA37, r[23:16], 8'h00, 1);
        add_step(op_rd, 32'h0000_0237, 8'h00, r[23:16], 1);
        // one access per target, latency checked in every transaction
        add_step(op_rd, ram_adrs[2], 8'h00, ram_dats[2], 2);
        add_step(op_rd, timer_adr(TMR_RELOAD_LO), 8'h00, 8'h00, 2);
        add_step(op_rd, prng_adr(1), 8'h00, 8'h00, 2);
        add_step(op_rd, timer_adr(TMR_STATUS), 8'h00, 8'h00, 2);
        s = 32'h0000_0001;
        for (int k = 0; k < 4; k++) begin
            add_step(op_rd, prng_adr(0), 8'h00, s[7:0], 3);
            s = prng_model(s);
        end
        // upper bytes must not step the state
        for (int k = 1; k < 4; k++) begin
            add_step(op_rd, prng_adr(k), 8'h00, s[8*k +: 8], 3);
        end
        add_step(op_rd, prng_adr(0), 8'h00, s[7:0], 3);
        next_rand(r);
        for (int k = 0; k < 4; k++) begin
            add_step(op_wr, prng_adr(k), r[8*k +: 8], 8'h00, 3);
        end
        s = r;
        for (int k = 0; k < 6; k++) begin
            add_step(op_rd, prng_adr(0), 8'h00, s[7:0], 3);
            s = prng_model(s);
        end
        add_step(op_wr, timer_adr(TMR_RELOAD_LO), 8'(RELOAD_LONG), 8'h00, 4);
        add_step(op_wr, timer_adr(TMR_RELOAD_HI), 8'(RELOAD_LONG >> 8), 8'h00, 4);
        add_step(op_rd, timer_adr(TMR_RELOAD_LO), 8'h00, 8'(RELOAD_LONG), 4);
        add_step(op_rd, timer_adr(TMR_RELOAD_HI), 8'h00, 8'(RELOAD_LONG >> 8), 4);
        add_step(op_wr, timer_adr(TMR_CTRL), 8'h01, 8'h00, 4);
        add_step(op_rd, timer_adr(TMR_CTRL), 8'h00, 8'h01, 4);
        add_step(op_rd, timer_adr(TMR_STATUS), 8'h00, 8'h00, 4);
        add_step(op_wait, long_wait, 8'h00, 8'h00, 4);
        add_step(op_rd, timer_adr(TMR_STATUS), 8'h00, 8'h01, 4);
        add_step(op_irq, 32'h0, 8'h00, 8'h00, 4);
        add_step(op_wr, timer_adr(TMR_CTRL), 8'h00, 8'h00, 4);
        add_step(op_wr, timer_adr(TMR_STATUS), 8'h01, 8'h00, 4);
        add_step(op_rd, timer_adr(TMR_STATUS), 8'h00, 8'h00, 4);
        add_step(op_wr, timer_adr(TMR_RELOAD_LO), 8'(RELOAD_SHORT), 8'h00, 5);
        add_step(op_wr, timer_adr(TMR_RELOAD_HI), 8'h00, 8'h00, 5);
        add_step(op_wr, timer_adr(TMR_CTRL), 8'h03, 8'h00, 5);
        add_step(op_wait, short_wait, 8'h00, 8'h00, 5);
        add_step(op_irq, 32'h0, 8'h00, 8'h01, 5);
        add_step(op_rd, timer_adr(TMR_STATUS), 8'h00, 8'h01, 5);
        // stop counting but keep the interrupt enabled
        add_step(op_wr, timer_adr(TMR_CTRL), 8'h02, 8'h00, 5);
        add_step(op_irq, 32'h0, 8'h00, 8'h01, 5);
        add_step(op_wr, timer_adr(TMR_STATUS), 8'h01, 8'h00, 5);
        add_step(op_irq, 32'h0, 8'h00, 8'h00, 5);
        add_step(op_rd, timer_adr(TMR_STATUS), 8'h00, 8'h00, 5);
        add_step(op_wr, timer_adr(TMR_CTRL), 8'h01, 8'h00, 5);
        add_step(op_wait, short_wait, 8'h00, 8'h00, 5);
        add_step(op_rd, timer_adr(TMR_STATUS), 8'h00, 8'h01, 5);
        add_step(op_irq, 32'h0, 8'h00, 8'h00, 5);
    endtask

    task automatic run_transaction(input step_t st, input int t);
        int cycles;
        @(negedge clk);
        req_i.adr = st.adr;
        req_i.dat = st.wdat;
        req_i.we  = (st.op == op_wr);
        stb_i     = 1'b1;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!rsp_o.ack && cycles < ACK_LIMIT);
        assert (rsp_o.ack) else begin
            $display("no acknowledge from address %08h within %0d cycles", st.adr, ACK_LIMIT);
            errs[t]++;
        end
        assert (cycles == 1) else begin
            $display("FAIL t=%0t ack latency expected 1 got %0d", $time, cycles);
            errs[t]++;
        end
        if (st.op == op_rd) begin
            assert (rsp_o.dat == st.exp) else begin
                $display("FAIL t=%0t rsp_o.dat expected %02h got %02h", $time, st.exp, rsp_o.dat);
                errs[t]++;
            end
        end
        stb_i    = 1'b0;
        req_i.we = 1'b0;
        @(negedge clk);
        assert (!rsp_o.ack) else begin
            $display("acknowledge from address %08h stayed high for two cycles", st.adr);
            errs[t]++;
        end
    endtask

    task automatic apply_step(input step_t st);
        int t;
        t = int'(st.test);
        case (st.op)
            op_wait: begin
                repeat (st.adr) @(negedge clk);
            end
            op_irq: begin
                @(negedge clk);
                assert (irq_o == st.exp[0]) else begin
                    $display("FAIL t=%0t irq_o expected %0b got %0b", $time, st.exp[0], irq_o);
                    errs[t]++;
                end
            end
            default: begin
                run_transaction(st, t);
            end
        endcase
    endtask

    task automatic report_test(input int t);
        if (errs[t] == 0) begin
            $display("test %0d: ok", t);
        end else begin
            $display("test %0d: %0d error(s)", t, errs[t]);
        end
    endtask

    initial begin
        int cur;
        int n_ok;
        int n_bad;
        arst_n_i = 1'b0;
        stb_i    = 1'b0;
        req_i    = '0;
        max_wait = 0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            errs[t] = 0;
        end
        build_table();
        foreach (steps[i]) begin
            if (steps[i].op == op_wait && int'(steps[i].adr) > max_wait) begin
                max_wait = int'(steps[i].adr);
            end
        end
        limit_cycles = steps.size() * (max_wait + 2 * ACK_LIMIT) + 100;
        table_built  = 1'b1;
        repeat (2) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        assert (!rsp_o.ack && !irq_o) else begin
            $display("acknowledge or interrupt high right after reset");
            errs[2]++;
        end
        cur = int'(steps[0].test);
        foreach (steps[i]) begin
            if (int'(steps[i].test) != cur) begin
                report_test(cur);
                cur = int'(steps[i].test);
            end
            apply_step(steps[i]);
        end
        report_test(cur);
        n_ok  = 0;
        n_bad = 0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            if (errs[t] == 0) begin
                n_ok++;
            end else begin
                n_bad++;
            end
        end
        $display("%0d tests ok, %0d tests with errors", n_ok, n_bad);
        if (n_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // bound from the table length and its longest wait
    initial begin
        wait (table_built);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("test failed");
        $finish;
    end

endmodule

// ==== bench/periph_bus_checker.sv ====
`timescale 1ns/1ps

module periph_bus_checker import soc_bus_pkg::*; (
    input logic     clk,
    input logic     arst_n_i,
    input logic     stb_i,
    input bus_rsp_t rsp_i,
    input logic     irq_i
);

    logic ack;

    assign ack = rsp_i.ack;

    // ack is a single-cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (!arst_n_i) ack |=> !ack)
        else $error("acknowledge high in two consecutive cycles");

    // no ack without a strobe one cycle earlier
    ack_after_stb: assert property (@(posedge clk) disable iff (!arst_n_i) ack |-> $past(stb_i))
        else $error("acknowledge without a strobe in the previous cycle");

    quiet_in_reset: assert property (@(posedge clk) !arst_n_i |-> (!ack && !irq_i))
        else $error("acknowledge or interrupt high during reset");

endmodule

bind periph_bus_top periph_bus_checker u_checker (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .stb_i    (stb_i),
    .rsp_i    (rsp_o),
    .irq_i    (irq_o)
);

// ==== logic/periph_bus_top.sv ====
`timescale 1ns/1ps

module periph_bus_top import soc_bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stb_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o,
    output logic     irq_o
);

    logic     ram_stb;
    logic     timer_stb;
    logic     prng_stb;
    bus_rsp_t ram_rsp;
    bus_rsp_t timer_rsp;
    bus_rsp_t prng_rsp;

    bus_decoder u_decoder (
        .stb_i       (stb_i),
        .req_i       (req_i),
        .ram_rsp_i   (ram_rsp),
        .timer_rsp_i (timer_rsp),
        .prng_rsp_i  (prng_rsp),
        .ram_stb_o   (ram_stb),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .rsp_o       (rsp_o)
    );

    // default target
    bram_wb8 u_ram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (ram_stb),
        .req_i    (req_i),
        .rsp_o    (ram_rsp)
    );

    // FFFFFDxx
    timer_wb8 u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (timer_stb),
        .req_i    (req_i),
        .rsp_o    (timer_rsp),
        .irq_o    (irq_o)
    );

    // FFFFFExx
    prng_wb8 u_prng (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (prng_stb),
        .req_i    (req_i),
        .rsp_o    (prng_rsp)
    );

endmodule

// ==== logic/timer_wb8.sv ====
`timescale 1ns/1ps

module timer_wb8 import soc_bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stb_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o,
    output logic     irq_o
);

    logic [15:0]              reload_q;
    logic [1:0]               ctrl_q;
    logic [TIMER_PS_BITS-1:0] ps_cnt;
    logic [15:0]              count;
    logic                     expired;
    logic                     irq_q;
    logic                     ack_q;
    logic                     access;
    logic                     wr;
    logic                     tick;
    logic                     expire;
    logic [1:0]               ofs;
    bus_dat_t                 rd_dat;

    assign ofs    = req_i.adr[1:0];
    assign access = stb_i && !ack_q;
    assign wr     = access && req_i.we;

    // prescaler phase runs regardless of enable
    assign tick   = ctrl_q[TMR_CTRL_EN] && (ps_cnt == TIMER_PS_BITS'(TIMER_PRESCALE - 1));
    assign expire = tick && (count == 16'd0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reload_q <= '0;
            ctrl_q   <= '0;
            ps_cnt   <= '0;
            count    <= '0;
            expired  <= 1'b0;
            irq_q    <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            ack_q  <= access;
            irq_q  <= expired && ctrl_q[TMR_CTRL_IE];
            ps_cnt <= (ps_cnt == TIMER_PS_BITS'(TIMER_PRESCALE - 1)) ? '0 : ps_cnt + 1'b1;

            if (tick) begin
                count <= expire ? reload_q : count - 16'd1;
            end

            if (wr && ofs == TMR_RELOAD_LO) begin
                reload_q[7:0] <= req_i.dat;
            end
            if (wr && ofs == TMR_RELOAD_HI) begin
                reload_q[15:8] <= req_i.dat;
            end
            if (wr && ofs == TMR_CTRL) begin
                ctrl_q <= req_i.dat[1:0];
                // enabling restarts the count from reload
                if (req_i.dat[TMR_CTRL_EN]) begin
                    count <= reload_q;
                end
            end

            // expiry beats a simultaneous clear
            if (expire) begin
                expired <= 1'b1;
            end else if (wr && ofs == TMR_STATUS && req_i.dat[0]) begin
                expired <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (ofs)
                TMR_RELOAD_LO: rd_dat <= reload_q[7:0];
                TMR_RELOAD_HI: rd_dat <= reload_q[15:8];
                TMR_CTRL:      rd_dat <= {6'b000000, ctrl_q};
                default:       rd_dat <= {7'b0000000, expired};
            endcase
        end
    end

    assign rsp_o = '{dat: rd_dat, ack: ack_q};
    assign irq_o = irq_q;

endmodule

// ==== logic/prng_wb8.sv ====
`timescale 1ns/1ps

module prng_wb8 import soc_bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stb_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o
);

    logic [31:0] state;
    logic [1:0]  ofs;
    bus_dat_t    rd_dat;
    logic        ack_q;
    logic        access;

    // one Galois step, zero is a fixed point
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] nxt;
        nxt = s >> 1;
        if (s[0]) begin
            nxt = nxt ^ PRNG_TAPS;
        end
        return nxt;
    endfunction

    assign ofs    = req_i.adr[1:0];
    assign access = stb_i && !ack_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= 32'h00000001;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (access) begin
                if (req_i.we) begin
                    state[{ofs, 3'b000} +: 8] <= req_i.dat;
                end else if (ofs == 2'd0) begin
                    state <= lfsr_step(state);
                end
            end
        end
    end

    // returns the byte as it was before any step
    always_ff @(posedge clk) begin
        if (access) begin
            rd_dat <= state[{ofs, 3'b000} +: 8];
        end
    end

    assign rsp_o = '{dat: rd_dat, ack: ack_q};

endmodule

// ==== logic/bram_wb8.sv ====
`timescale 1ns/1ps

module bram_wb8 import soc_bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stb_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o
);

    bus_dat_t mem [2**RAM_ADDR_BITS];
    ram_adr_t word_adr;
    bus_dat_t rd_dat;
    logic     ack_q;
    logic     access;

    assign word_adr = req_i.adr[RAM_ADDR_BITS-1:0];

    // new access only while the previous ack is not showing
    assign access = stb_i && !ack_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // read-before-write on the same index
    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                mem[word_adr] <= req_i.dat;
            end
            rd_dat <= mem[word_adr];
        end
    end

    assign rsp_o = '{dat: rd_dat, ack: ack_q};

endmodule

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder import soc_bus_pkg::*; (
    input  logic     stb_i,
    input  bus_req_t req_i,
    input  bus_rsp_t ram_rsp_i,
    input  bus_rsp_t timer_rsp_i,
    input  bus_rsp_t prng_rsp_i,
    output logic     ram_stb_o,
    output logic     timer_stb_o,
    output logic     prng_stb_o,
    output bus_rsp_t rsp_o
);

    bus_target_e target;

    // page decode, everything unclaimed lands in RAM
    always_comb begin
        casez (req_i.adr)
            {TIMER_BASE, 8'b????????}: begin
                target = tgt_timer;
            end
            {PRNG_BASE, 8'b????????}: begin
                target = tgt_prng;
            end
            // reserved FFFFFAxx and FFFFFBxx pages alias into RAM
            default: begin
                target = tgt_ram;
            end
        endcase
    end

    // strobe goes only to the addressed target
    always_comb begin
        ram_stb_o   = 1'b0;
        timer_stb_o = 1'b0;
        prng_stb_o  = 1'b0;
        case (target)
            tgt_timer: begin
                timer_stb_o = stb_i;
            end
            tgt_prng: begin
                prng_stb_o = stb_i;
            end
            default: begin
                ram_stb_o = stb_i;
            end
        endcase
    end

    // response return
    always_comb begin
        case (target)
            tgt_timer: begin
                rsp_o = timer_rsp_i;
            end
            tgt_prng: begin
                rsp_o = prng_rsp_i;
            end
            default: begin
                rsp_o = ram_rsp_i;
            end
        endcase
    end

endmodule

// ==== logic/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // bus widths
    typedef logic [31:0] bus_adr_t;
    typedef logic [7:0]  bus_dat_t;

    // upper 24 address bits select a peripheral page
    typedef logic [23:0] bus_page_t;

    typedef struct packed {
        bus_adr_t adr;
        bus_dat_t dat;
        logic     we;
    } bus_req_t;

    typedef struct packed {
        bus_dat_t dat;
        logic     ack;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        tgt_ram,
        tgt_timer,
        tgt_prng
    } bus_target_e;

    // address map
    localparam bus_page_t TIMER_BASE = 24'hFFFFFD;
    localparam bus_page_t PRNG_BASE  = 24'hFFFFFE;

    // block RAM, higher address bits alias
    localparam int RAM_ADDR_BITS = 10;
    typedef logic [RAM_ADDR_BITS-1:0] ram_adr_t;

    // timer
    localparam int TIMER_PRESCALE = 4;
    localparam int TIMER_PS_BITS  = $clog2(TIMER_PRESCALE);

    localparam logic [1:0] TMR_RELOAD_LO = 2'd0;
    localparam logic [1:0] TMR_RELOAD_HI = 2'd1;
    localparam logic [1:0] TMR_CTRL      = 2'd2;
    localparam logic [1:0] TMR_STATUS    = 2'd3;

    // control bits
    localparam int TMR_CTRL_EN  = 0;
    localparam int TMR_CTRL_IE  = 1;

    // Galois LFSR feedback mask
    localparam logic [31:0] PRNG_TAPS = 32'h80200003;

endpackage
